// File: preamble_gen.f
+incdir+source
+incdir+test
source/preamble_pkg.sv
source/stf_rom.sv
source/ltf_rom.sv
source/preamble_sequencer.sv
source/preamble_gen.sv
test/preamble_gen_tb.sv

// File: source/ltf_rom.sv
`timescale 1ns/1ps
`include "preamble_params.svh"

module ltf_rom (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                restart_i,  // Back to guard offset
    input  logic                step_i,     // Present beat and advance
    output preamble_pkg::beat_t beat_o
);

    localparam int ADDR_W = $clog2(`PRE_LTF_LEN);

    ////////////////////////////////////////////////////////////////////////////
    // Long training symbol, {im, re}
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [2*`PRE_IQ_W-1:0] LTF_TBL [`PRE_LTF_LEN] = '{
        24'h000140,     // Symbol start, real peak
        24'hF0AFF6,
        24'hF1C051,
        24'h0AA0C6,
        24'h03902B,
        24'hF4C07B,
        24'hF8FF14,
        24'hF27FB2,
        24'hFCB0C8,
        24'h00806D,
        24'hF14002,
        24'hF9FEE8,
        24'hF88032,
        24'hFE1078,
        24'h149FD2,
        24'hFF80F4,
        24'hF80080,     // Quarter symbol
        24'h0C904C,
        24'h050F8B,
        24'h086EF3,
        24'h0BD0A8,
        24'h01D08E,
        24'h0A6F84,
        24'hFD3F8C,
        24'hECBFB8,
        24'hFDEF06,
        24'hFD6EFB,
        24'hF6809A,
        24'h06EFFA,
        24'h0ECF44,
        24'h0D90BC,
        24'h0C8019,
        24'h000EC0,     // Guard interval copies from here
        24'hF38019,
        24'hF270BC,
        24'hF14F44,
        24'hF92FFA,
        24'h09809A,
        24'h02AEFB,
        24'h022F06,
        24'h135FB8,
        24'h02DF8C,
        24'hF5AF84,
        24'hFE308E,
        24'hF430A8,
        24'hF7AEF3,
        24'hFB0F8B,
        24'hF3704C,
        24'h080080,     // Three quarter point
        24'h0080F4,
        24'hEB7FD2,
        24'h01F078,
        24'h078032,
        24'h061EE8,
        24'h0EC002,
        24'hFF806D,
        24'h0350C8,
        24'h0D9FB2,
        24'h071F14,
        24'h0B407B,
        24'hFC702B,
        24'hF560C6,
        24'h0E4051,
        24'h0F6FF6      // Last sample, wraps to entry 0
    };

    logic [ADDR_W-1:0] addr_q;  // Sample address of lane 0

    // Starting at the guard offset yields GI, symbol, symbol from one table
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            addr_q <= ADDR_W'(`PRE_LTF_GI);
        end else if (restart_i) begin
            addr_q <= ADDR_W'(`PRE_LTF_GI);         // Second half first
        end else if (step_i) begin
            addr_q <= addr_q + ADDR_W'(`PRE_LANES); // Modulo 64 wrap
        end
    end

    // Registered read
    always_ff @(posedge clk_i) begin
        if (step_i) begin
            for (int l = 0; l < `PRE_LANES; l++) begin
                beat_o[l] <= LTF_TBL[ADDR_W'(addr_q + l)];
            end
        end
    end

    // Lane addresses never straddle the wrap point
    a_addr_aligned: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (addr_q % `PRE_LANES) == 0
    ) else $error("ltf_rom address not beat aligned");

endmodule

// File: source/preamble_gen.sv
`timescale 1ns/1ps

module preamble_gen (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                header_en_i,    // Run request level
    output preamble_pkg::beat_t beat_o,         // Four samples per clock
    output logic                valid_o,
    output logic                done_o
);

    preamble_pkg::beat_t stf_beat;      // Short table output
    preamble_pkg::beat_t ltf_beat;      // Long table output
    logic                restart;
    logic                stf_step;
    logic                ltf_step;

    stf_rom u_stf_rom (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .restart_i (restart),
        .step_i    (stf_step),
        .beat_o    (stf_beat)
    );

    ltf_rom u_ltf_rom (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .restart_i (restart),
        .step_i    (ltf_step),
        .beat_o    (ltf_beat)
    );

    // Picks the table and frames the stream
    preamble_sequencer u_sequencer (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .header_en_i (header_en_i),
        .stf_beat_i  (stf_beat),
        .ltf_beat_i  (ltf_beat),
        .restart_o   (restart),
        .stf_step_o  (stf_step),
        .ltf_step_o  (ltf_step),
        .beat_o      (beat_o),
        .valid_o     (valid_o),
        .done_o      (done_o)
    );

endmodule

// File: source/preamble_params.svh
`ifndef PREAMBLE_PARAMS_SVH
`define PREAMBLE_PARAMS_SVH

// Sample format
`define PRE_IQ_W        12      // Bits per I or Q component
`define PRE_LANES       4       // Samples per beat

// Table sizes
`define PRE_STF_LEN     16      // One short training period
`define PRE_LTF_LEN     64      // One long training symbol
`define PRE_LTF_GI      32      // Long guard length and start address

// Field lengths in beats
`define PRE_STF_BEATS   40      // 160 short samples
`define PRE_TOTAL_BEATS 80      // Full 320 sample preamble

`endif

// File: source/preamble_pkg.sv
`include "preamble_params.svh"

package preamble_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sample and beat types
    ////////////////////////////////////////////////////////////////////////////

    // Same bit order as the {im, re} table word
    typedef struct packed {
        logic signed [`PRE_IQ_W-1:0] im;    // Quadrature part
        logic signed [`PRE_IQ_W-1:0] re;    // In-phase part
    } iq_sample_t;

    // Lane 0 carries the earliest sample of the beat
    typedef iq_sample_t [`PRE_LANES-1:0] beat_t;

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer states
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        PRE_IDLE = 2'd0,    // Waiting for enable
        PRE_STF  = 2'd1,    // Short field beats
        PRE_LTF  = 2'd2,    // Long field beats
        PRE_DONE = 2'd3     // Finished, waiting for enable low
    } pre_state_e;

endpackage

// File: source/preamble_sequencer.sv
`timescale 1ns/1ps
`include "preamble_params.svh"

module preamble_sequencer (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                header_en_i,    // Level, high for whole run
    input  preamble_pkg::beat_t stf_beat_i,
    input  preamble_pkg::beat_t ltf_beat_i,
    output logic                restart_o,      // Start cycle pulse
    output logic                stf_step_o,
    output logic                ltf_step_o,
    output preamble_pkg::beat_t beat_o,
    output logic                valid_o,
    output logic                done_o          // After last valid beat
);

    localparam int CNT_W = 7;

    preamble_pkg::pre_state_e state_q;
    logic [CNT_W-1:0]         beat_cnt_q;   // Beats stepped so far
    logic                     rom_vld_q;    // ROM output holds a beat
    logic                     sel_ltf_q;    // ROM output is from ltf_rom
    logic                     last_step;
    logic [1:0]               last_q;       // Last step, following ROM and output stage

    // Strobes to the tables
    assign restart_o  = (state_q == preamble_pkg::PRE_IDLE) && header_en_i;
    assign stf_step_o = (state_q == preamble_pkg::PRE_STF) && header_en_i;
    assign ltf_step_o = (state_q == preamble_pkg::PRE_LTF) && header_en_i;
    assign last_step  = ltf_step_o && (beat_cnt_q == CNT_W'(`PRE_TOTAL_BEATS - 1));

    ////////////////////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= preamble_pkg::PRE_IDLE;
            beat_cnt_q <= '0;
        end else begin
            case (state_q)
                preamble_pkg::PRE_IDLE: begin
                    if (header_en_i) begin
                        state_q    <= preamble_pkg::PRE_STF;
                        beat_cnt_q <= '0;       // Always from sample 0
                    end
                end
                preamble_pkg::PRE_STF: begin
                    if (!header_en_i) begin
                        state_q <= preamble_pkg::PRE_IDLE;  // Abort
                    end else begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                        if (beat_cnt_q == CNT_W'(`PRE_STF_BEATS - 1)) begin
                            state_q <= preamble_pkg::PRE_LTF;
                        end
                    end
                end
                preamble_pkg::PRE_LTF: begin
                    if (!header_en_i) begin
                        state_q <= preamble_pkg::PRE_IDLE;  // Abort
                    end else begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                        if (last_step) begin
                            state_q <= preamble_pkg::PRE_DONE;
                        end
                    end
                end
                preamble_pkg::PRE_DONE: begin
                    if (!header_en_i) begin
                        state_q <= preamble_pkg::PRE_IDLE;  // Held enable waits here
                    end
                end
                default: state_q <= preamble_pkg::PRE_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output stage, one cycle behind the tables
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rom_vld_q <= 1'b0;
            sel_ltf_q <= 1'b0;
            valid_o   <= 1'b0;
            beat_o    <= '0;
            last_q    <= '0;
            done_o    <= 1'b0;
        end else begin
            rom_vld_q <= stf_step_o || ltf_step_o;
            sel_ltf_q <= ltf_step_o;            // Follows ROM latency
            valid_o   <= rom_vld_q;
            if (!rom_vld_q) begin
                beat_o <= '0;                   // Quiet between runs
            end else if (sel_ltf_q) begin
                beat_o <= ltf_beat_i;
            end else begin
                beat_o <= stf_beat_i;
            end
            last_q <= {last_q[0], last_step};
            done_o <= last_q[1];                // Lands after beat 80
        end
    end

    // Checks
    a_valid_done_excl: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(valid_o && done_o)
    ) else $error("valid_o and done_o high together");

    a_cnt_bound: assert property (
        @(posedge clk_i) disable iff (rst_i)
        beat_cnt_q <= CNT_W'(`PRE_TOTAL_BEATS)
    ) else $error("beat counter past end of preamble");

endmodule

// File: source/stf_rom.sv
`timescale 1ns/1ps
`include "preamble_params.svh"

module stf_rom (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                restart_i,  // Back to sample 0
    input  logic                step_i,     // Present beat and advance
    output preamble_pkg::beat_t beat_o
);

    localparam int BLK_W = $clog2(`PRE_STF_LEN / `PRE_LANES); // Beats per period
    localparam int IDX_W = $clog2(`PRE_STF_LEN);

    // One short training period, {im, re}
    localparam logic [2*`PRE_IQ_W-1:0] STF_TBL [`PRE_STF_LEN] = '{
        24'h05E05E, 24'h005EF1, 24'hF5FFE4, 24'hFE6124,
        24'h0000BC, 24'hFE6124, 24'hF5FFE4, 24'h005EF1,
        24'h05E05E, 24'hEF1005, 24'hFE4F5F, 24'h124FE6,
        24'h0BC000, 24'h124FE6, 24'hFE4F5F, 24'hEF1005
    };

    logic [BLK_W-1:0] blk_q;    // Beat within the period

    // Block counter wraps every period, giving the ten repeats for free
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            blk_q <= '0;
        end else if (restart_i) begin
            blk_q <= '0;                    // New preamble
        end else if (step_i) begin
            blk_q <= blk_q + 1'b1;          // Natural wrap
        end
    end

    // Registered read, one cycle from strobe to data
    always_ff @(posedge clk_i) begin
        if (step_i) begin
            for (int l = 0; l < `PRE_LANES; l++) begin
                beat_o[l] <= STF_TBL[IDX_W'(blk_q * `PRE_LANES + l)];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Sequencer restarts only from idle, never while stepping
    a_no_step_on_restart: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(step_i && restart_i)
    ) else $error("stf_rom step and restart in the same cycle");

endmodule

// File: test/preamble_checks.svh
////////////////////////////////////////////////////////////////////////////
// Reference values of the standard preamble
////////////////////////////////////////////////////////////////////////////

localparam int STF_SAMPLES = `PRE_STF_BEATS * `PRE_LANES;       // Sample 160 starts LTF
localparam int LTF_SYM0    = STF_SAMPLES + `PRE_LTF_GI;         // First full symbol
localparam int LTF_SYM1    = LTF_SYM0 + `PRE_LTF_LEN;           // Second full symbol

// Short period, real and imaginary parts per sample
localparam logic [`PRE_IQ_W-1:0] STF_RE [`PRE_STF_LEN] = '{
    12'h05E, 12'hEF1, 12'hFE4, 12'h124, 12'h0BC, 12'h124, 12'hFE4, 12'hEF1,
    12'h05E, 12'h005, 12'hF5F, 12'hFE6, 12'h000, 12'hFE6, 12'hF5F, 12'h005
};
localparam logic [`PRE_IQ_W-1:0] STF_IM [`PRE_STF_LEN] = '{
    12'h05E, 12'h005, 12'hF5F, 12'hFE6, 12'h000, 12'hFE6, 12'hF5F, 12'h005,
    12'h05E, 12'hEF1, 12'hFE4, 12'h124, 12'h0BC, 12'h124, 12'hFE4, 12'hEF1
};
localparam logic [`PRE_IQ_W-1:0] LTF_GI_RE  = 12'hEC0;         // Sample 160, im zero
localparam logic [`PRE_IQ_W-1:0] LTF_SYM_RE = 12'h140;         // Sample 192, im zero

preamble_pkg::iq_sample_t seen [2 * STF_SAMPLES];               // Samples of the current run

function automatic preamble_pkg::iq_sample_t make_sample(input logic [`PRE_IQ_W-1:0] re,
                                                         input logic [`PRE_IQ_W-1:0] im);
    preamble_pkg::iq_sample_t s;
    s.re = re;
    s.im = im;
    return s;
endfunction

task automatic check_sample(input string name, input preamble_pkg::iq_sample_t exp,
                            input preamble_pkg::iq_sample_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("FAILED %s expected %h actual %h", name, exp, act);
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("FAILED %s expected %h actual %h", name, exp, act);
    end
endtask

// Four lanes of beat b against the field rules
task automatic compare_beat(input int b);
    int    n;
    string nm;
    for (int l = 0; l < `PRE_LANES; l++) begin
        n       = b * `PRE_LANES + l;
        nm      = $sformatf("beat_o[%0d] sample %0d", l, n);
        seen[n] = beat_o[l];
        if (n < STF_SAMPLES) begin
            check_sample(nm, make_sample(STF_RE[n % `PRE_STF_LEN],
                                         STF_IM[n % `PRE_STF_LEN]), beat_o[l]);
        end else if (n == STF_SAMPLES) begin
            check_sample(nm, make_sample(LTF_GI_RE, '0), beat_o[l]);
        end else if (n == LTF_SYM0) begin
            check_sample(nm, make_sample(LTF_SYM_RE, '0), beat_o[l]);
        end else if (n >= LTF_SYM1 - `PRE_LTF_GI) begin
            check_sample(nm, seen[n - `PRE_LTF_LEN], beat_o[l]);   // Symbol repeats every 64
        end
    end
endtask

// No beat, no done, zero data
task automatic expect_quiet();
    check_flag("valid_o", 1'b0, valid_o);
    check_flag("done_o", 1'b0, done_o);
    for (int l = 0; l < `PRE_LANES; l++) begin
        check_sample($sformatf("beat_o[%0d]", l), '0, beat_o[l]);
    end
endtask

// File: test/preamble_gen_tb.sv
`timescale 1ns/1ps
`include "preamble_params.svh"

module preamble_gen_tb;

    localparam int NUM_TESTS = 24;
    localparam int CYC_LIMIT = (NUM_TESTS + 1) * (`PRE_TOTAL_BEATS + 10 + 10); // One extra for reset

    logic                clk_i;
    logic                rst_i;
    logic                header_en_i;
    preamble_pkg::beat_t beat_o;
    logic                valid_o;
    logic                done_o;

    integer seed;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;

    `include "preamble_checks.svh"

    preamble_gen uut (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .header_en_i (header_en_i),
        .beat_o      (beat_o),
        .valid_o     (valid_o),
        .done_o      (done_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;                 // 40 ns period
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > CYC_LIMIT) begin
            $display("Timeout after %0d cycles, the preamble never completed", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and checking, all on the falling edge
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int hold;
        int drop_at;
        int gap;
        int n_beats;
        int wait_cyc;
        int test_err;
        seed        = 6730;
        rst_i       = 1'b1;
        header_en_i = 1'b0;
        repeat (16) @(negedge clk_i);
        rst_i = 1'b0;
        repeat (4) begin
            @(negedge clk_i);
            expect_quiet();                         // Nothing before first enable
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_err    = errors;
            hold        = $unsigned($random(seed)) % 2;
            drop_at     = 1 + $unsigned($random(seed)) % 78;   // Beats seen before the drop
            gap         = $unsigned($random(seed)) % 11;
            n_beats     = hold ? `PRE_TOTAL_BEATS : drop_at + 1; // ROM holds one more
            wait_cyc    = 0;
            header_en_i = 1'b1;
            do begin
                @(negedge clk_i);
                wait_cyc++;
            end while (!valid_o);
            if (wait_cyc != 3) begin
                errors++;
                $display("First beat came %0d cycles after enable instead of 3", wait_cyc);
            end
            for (int b = 0; b < n_beats; b++) begin
                check_flag("valid_o", 1'b1, valid_o);               // Contiguous beats
                check_flag("done_o", 1'b0, done_o);                 // Pulse comes after the stream
                compare_beat(b);
                if (!hold && b == drop_at - 1) begin
                    header_en_i = 1'b0;                              // Abort mid run
                end
                @(negedge clk_i);
            end
            check_flag("valid_o", 1'b0, valid_o);   // Stream has ended
            check_flag("done_o", hold != 0, done_o); // Only a full run ends with done
            @(negedge clk_i);
            repeat (4) begin
                expect_quiet();                     // Held enable must not restart
                @(negedge clk_i);
            end
            header_en_i = 1'b0;
            repeat (1 + gap) begin
                expect_quiet();
                @(negedge clk_i);
            end
            $display("test %0d %s, %0d beats, %0d errors", t, hold ? "full run" : "abort",
                     n_beats, errors - test_err);
        end
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
